// ==== fp32_pkg.sv ====
////////////////////
// binary32 format definitions
// field widths, bias, field types and rounding modes
////////////////////

package fp32_pkg;

  // field widths
  localparam int FP32_W      = 32;
  localparam int FP32_EXP_W  = 8;
  localparam int FP32_MANT_W = 23;

  // exponent bias
  localparam int FP32_BIAS   = 127;

  // biased exponent, stored fraction, packed word
  typedef logic [FP32_EXP_W-1:0]  fp32_exp_t;
  typedef logic [FP32_MANT_W-1:0] fp32_mant_t;
  typedef logic [FP32_W-1:0]      fp32_word_t;

  // rounding modes, encoded as in the FPU control register
  typedef enum logic [1:0] {
    RND_NEAREST_EVEN = 2'd0,
    RND_TO_ZERO      = 2'd1,
    RND_TO_PLUS_INF  = 2'd2,
    RND_TO_MINUS_INF = 2'd3
  } rnd_mode_e;

endpackage

// ==== i2f_pkg.sv ====
////////////////////
// integer to float stage data
// operand, shift and exponent base definitions
////////////////////

package i2f_pkg;

  // integer operand width
  localparam int I2F_INT_W = 32;

  // operand and its magnitude
  typedef logic [I2F_INT_W-1:0] i2f_int_t;

  // right shift for leading one in [31:24], range 0..8
  typedef logic [3:0] i2f_shr_t;

  // left shift for leading one in [22:0], range 0..23
  typedef logic [4:0] i2f_shl_t;

  // exponent of a value whose leading one sits in bit 23
  // 127 + 23 = 150
  localparam int I2F_EXP_BASE = fp32_pkg::FP32_BIAS + fp32_pkg::FP32_MANT_W;

endpackage

// ==== i2f_prenorm.sv ====
////////////////////
// int to float, stage one
// sign, magnitude, leading one and exponent candidates
////////////////////

`timescale 1ns/1ps

module i2f_prenorm (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  flush_i,
  input  logic                  adv_i,
  input  logic                  start_i,
  input  fp32_pkg::rnd_mode_e   rnd_mode_i,
  input  i2f_pkg::i2f_int_t     opa_i,
  output logic                  rdy_o,
  output logic                  sign_o,
  output fp32_pkg::rnd_mode_e   rnd_mode_o,
  output i2f_pkg::i2f_shr_t     shr_o,
  output i2f_pkg::i2f_shl_t     shl_o,
  output fp32_pkg::fp32_exp_t   exp_shr_o,
  output fp32_pkg::fp32_exp_t   exp_shl_o,
  output fp32_pkg::fp32_exp_t   exp_sh0_o,
  output i2f_pkg::i2f_int_t     fract_o
);

  // base exponent in the 8-bit field type
  localparam fp32_pkg::fp32_exp_t EXP_BASE = fp32_pkg::fp32_exp_t'(i2f_pkg::I2F_EXP_BASE);

  logic              sign;
  i2f_pkg::i2f_int_t mag;
  i2f_pkg::i2f_shr_t shr;
  i2f_pkg::i2f_shl_t shl;

  ////////////////////
  // sign and magnitude
  ////////////////////

  assign sign = opa_i[31];

  // two's complement for negative input
  // -2^31 stays 0x80000000, still correct as unsigned
  assign mag = (opa_i ^ {32{sign}}) + {31'd0, sign};

  ////////////////////
  // leading one
  ////////////////////

  // target: hidden one in bit 23
  // one above bit 23 needs a right shift
  always_comb begin
    shr = '0;
    // lowest first, highest set bit wins
    for (int i = 0; i < 8; i++) begin
      if (mag[24+i]) begin
        shr = i2f_pkg::i2f_shr_t'(i + 1);
      end
    end
  end

  // one below bit 23 needs a left shift
  // only used when [31:23] is all zero
  always_comb begin
    shl = '0;
    for (int i = 0; i < 24; i++) begin
      if (mag[i]) begin
        shl = i2f_pkg::i2f_shl_t'(23 - i);
      end
    end
  end

  ////////////////////
  // stage registers
  ////////////////////

  // payload, no reset
  always_ff @(posedge clk) begin
    if (adv_i) begin
      sign_o     <= sign;
      rnd_mode_o <= rnd_mode_i;
      shr_o      <= shr;
      shl_o      <= shl;
      // three exponent candidates, picked in stage two
      exp_shr_o  <= EXP_BASE + {4'd0, shr};
      exp_shl_o  <= EXP_BASE - {3'd0, shl};
      // zero magnitude lands here with exponent 0
      exp_sh0_o  <= mag[23] ? EXP_BASE : '0;
      fract_o    <= mag;
    end
  end

  // ready flag, flush wins over advance
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rdy_o <= 1'b0;
    end else if (flush_i) begin
      rdy_o <= 1'b0;
    end else if (adv_i) begin
      rdy_o <= start_i;
    end
  end

endmodule

// ==== i2f_postnorm.sv ====
////////////////////
// int to float, stage two
// normalize, round and pack the binary32 result
////////////////////

`timescale 1ns/1ps

module i2f_postnorm (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  flush_i,
  input  logic                  adv_i,
  input  logic                  rdy_i,
  input  logic                  sign_i,
  input  fp32_pkg::rnd_mode_e   rnd_mode_i,
  input  i2f_pkg::i2f_shr_t     shr_i,
  input  i2f_pkg::i2f_shl_t     shl_i,
  input  fp32_pkg::fp32_exp_t   exp_shr_i,
  input  fp32_pkg::fp32_exp_t   exp_shl_i,
  input  fp32_pkg::fp32_exp_t   exp_sh0_i,
  input  i2f_pkg::i2f_int_t     fract_i,
  output fp32_pkg::fp32_word_t  result_o,
  output logic                  inexact_o,
  output logic                  rdy_o
);

  // magnitude with 8 extra bits below for guard and sticky
  logic [39:0]          fract_sh;
  logic [23:0]          sig;
  logic                 guard;
  logic                 sticky;
  logic                 sign;
  fp32_pkg::fp32_exp_t  exp_sel;
  logic                 rnd_up;
  logic [24:0]          sig_rnd;
  fp32_pkg::fp32_exp_t  exp_fin;
  fp32_pkg::fp32_mant_t mant_fin;

  ////////////////////
  // normalization
  ////////////////////

  // at most 8 bits drop off, all caught in [7:0]
  assign fract_sh = {fract_i, 8'd0} >> shr_i;

  always_comb begin
    sig     = '0;
    guard   = 1'b0;
    sticky  = 1'b0;
    sign    = sign_i;
    exp_sel = exp_sh0_i;
    if (shr_i != '0) begin
      // wide value, leading one now at bit 31 of fract_sh
      sig     = fract_sh[31:8];
      guard   = fract_sh[7];
      sticky  = |fract_sh[6:0];
      exp_sel = exp_shr_i;
    end else if (fract_i[23]) begin
      // already normalized
      sig     = fract_i[23:0];
    end else if (fract_i != '0) begin
      // small value, exact after left shift
      sig     = fract_i[23:0] << shl_i;
      exp_sel = exp_shl_i;
    end else begin
      // zero in, +0 out
      sign    = 1'b0;
    end
  end

  ////////////////////
  // rounding
  ////////////////////

  always_comb begin
    unique case (rnd_mode_i)
      // ties go to even lsb
      fp32_pkg::RND_NEAREST_EVEN: rnd_up = guard & (sticky | sig[0]);
      fp32_pkg::RND_TO_ZERO:      rnd_up = 1'b0;
      fp32_pkg::RND_TO_PLUS_INF:  rnd_up = ~sign & (guard | sticky);
      fp32_pkg::RND_TO_MINUS_INF: rnd_up = sign & (guard | sticky);
    endcase
  end

  assign sig_rnd = {1'b0, sig} + {24'd0, rnd_up};

  // carry out means 2^24, shift right once and bump exponent
  // max exponent is 158, no overflow from an integer source
  always_comb begin
    if (sig_rnd[24]) begin
      mant_fin = sig_rnd[23:1];
      exp_fin  = exp_sel + 8'd1;
    end else begin
      mant_fin = sig_rnd[22:0];
      exp_fin  = exp_sel;
    end
  end

  ////////////////////
  // output registers
  ////////////////////

  always_ff @(posedge clk) begin
    if (adv_i) begin
      result_o  <= {sign, exp_fin, mant_fin};
      // any dropped bit set
      inexact_o <= guard | sticky;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rdy_o <= 1'b0;
    end else if (flush_i) begin
      rdy_o <= 1'b0;
    end else if (adv_i) begin
      rdy_o <= rdy_i;
    end
  end

endmodule

// ==== i2f_unit.sv ====
////////////////////
// int to float converter, two pipe stages
////////////////////

`timescale 1ns/1ps

module i2f_unit (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 flush_i,
  input  logic                 adv_i,
  input  logic                 start_i,
  input  fp32_pkg::rnd_mode_e  rnd_mode_i,
  input  i2f_pkg::i2f_int_t    opa_i,
  output fp32_pkg::fp32_word_t result_o,
  output logic                 inexact_o,
  output logic                 rdy_o
);

  // stage one to stage two
  logic                pre_rdy;
  logic                pre_sign;
  fp32_pkg::rnd_mode_e pre_rnd_mode;
  i2f_pkg::i2f_shr_t   pre_shr;
  i2f_pkg::i2f_shl_t   pre_shl;
  fp32_pkg::fp32_exp_t pre_exp_shr;
  fp32_pkg::fp32_exp_t pre_exp_shl;
  fp32_pkg::fp32_exp_t pre_exp_sh0;
  i2f_pkg::i2f_int_t   pre_fract;

  // stage one, rounding mode rides along
  i2f_prenorm u_prenorm (
    .clk        (clk),
    .rst        (rst),
    .flush_i    (flush_i),
    .adv_i      (adv_i),
    .start_i    (start_i),
    .rnd_mode_i (rnd_mode_i),
    .opa_i      (opa_i),
    .rdy_o      (pre_rdy),
    .sign_o     (pre_sign),
    .rnd_mode_o (pre_rnd_mode),
    .shr_o      (pre_shr),
    .shl_o      (pre_shl),
    .exp_shr_o  (pre_exp_shr),
    .exp_shl_o  (pre_exp_shl),
    .exp_sh0_o  (pre_exp_sh0),
    .fract_o    (pre_fract)
  );

  // stage two
  i2f_postnorm u_postnorm (
    .clk        (clk),
    .rst        (rst),
    .flush_i    (flush_i),
    .adv_i      (adv_i),
    .rdy_i      (pre_rdy),
    .sign_i     (pre_sign),
    .rnd_mode_i (pre_rnd_mode),
    .shr_i      (pre_shr),
    .shl_i      (pre_shl),
    .exp_shr_i  (pre_exp_shr),
    .exp_shl_i  (pre_exp_shl),
    .exp_sh0_i  (pre_exp_sh0),
    .fract_i    (pre_fract),
    .result_o   (result_o),
    .inexact_o  (inexact_o),
    .rdy_o      (rdy_o)
  );

endmodule

// ==== i2f_checker.sv ====
////////////////////
// int to float checker
// expectation queue, latency and value compare
////////////////////

`timescale 1ns/1ps

module i2f_checker (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 adv_i,
  input  logic                 flush_i,
  input  logic                 rdy_i,
  input  fp32_pkg::fp32_word_t result_i,
  input  logic                 inexact_i,
  input  logic                 exp_push_i,
  input  fp32_pkg::fp32_word_t exp_result_i,
  input  logic                 exp_inexact_i,
  output int                   value_errs_o,
  output int                   proto_errs_o,
  output int                   pending_o
);

  // one entry per started operand, tagged with its start edge
  typedef struct packed {
    logic                 sign;
    fp32_pkg::fp32_exp_t  expo;
    fp32_pkg::fp32_mant_t mant;
    logic                 inexact;
    logic [31:0]          edge_idx;
  } exp_entry_t;

  exp_entry_t           exp_q[$];
  exp_entry_t           head;
  fp32_pkg::fp32_word_t exp_word;
  int unsigned          adv_cnt = 0;
  int                   value_errs = 0;
  int                   proto_errs = 0;
  int                   pending = 0;

  assign value_errs_o = value_errs;
  assign proto_errs_o = proto_errs;
  assign pending_o    = pending;

  always @(posedge clk) begin
    if (rst) begin
      if (rdy_i !== 1'b0) begin
        proto_errs++;
        $display("%0t: rdy_o is high during reset", $time);
      end
      exp_q.delete();
      adv_cnt = 0;
    end else if (flush_i) begin
      // everything in flight is dropped, a same-cycle start too
      exp_q.delete();
    end else if (adv_i) begin
      if (rdy_i && exp_q.size() == 0) begin
        proto_errs++;
        $display("%0t: rdy_o is high with no operand in flight", $time);
      end else if (rdy_i) begin
        head     = exp_q.pop_front();
        exp_word = {head.sign, head.expo, head.mant};
        // result belongs to the start two adv edges back
        if (head.edge_idx + 32'd2 != adv_cnt) begin
          proto_errs++;
          $display("%0t: result came at adv edge %0d, expected at %0d",
                   $time, adv_cnt, head.edge_idx + 32'd2);
        end
        if (result_i !== exp_word) begin
          value_errs++;
          $display("CHECK FAILED at %0t: result_o expected %h, got %h",
                   $time, exp_word, result_i);
        end
        if (inexact_i !== head.inexact) begin
          value_errs++;
          $display("CHECK FAILED at %0t: inexact_o expected %b, got %b",
                   $time, head.inexact, inexact_i);
        end
      end else if (exp_q.size() != 0 && exp_q[0].edge_idx + 32'd2 <= adv_cnt) begin
        proto_errs++;
        head = exp_q.pop_front();
        $display("%0t: result for the operand started at adv edge %0d never came",
                 $time, head.edge_idx);
      end
      if (exp_push_i) begin
        exp_q.push_back({exp_result_i[31], exp_result_i[30:23], exp_result_i[22:0],
                         exp_inexact_i, adv_cnt});
      end
      adv_cnt++;
    end
    pending = exp_q.size();
  end

endmodule

// ==== tb_i2f_unit.sv ====
////////////////////
// int to float testbench
// table rows, back-pressure and flush
////////////////////

`timescale 1ns/1ps

module tb_i2f_unit;

  localparam int NROWS = 20;
  // 20 cycles per row applied plus 200
  localparam int LIMIT = 20 * (2 * NROWS + 4) + 200;

  typedef struct packed {
    i2f_pkg::i2f_int_t    op;
    fp32_pkg::rnd_mode_e  mode;
    fp32_pkg::fp32_word_t result;
    logic                 inexact;
  } row_t;

  // operand, rounding mode, expected word, expected inexact
  localparam row_t ROWS [NROWS] = '{
    '{32'h00000000, fp32_pkg::RND_NEAREST_EVEN, 32'h00000000, 1'b0},
    '{32'h00000001, fp32_pkg::RND_NEAREST_EVEN, 32'h3F800000, 1'b0},
    '{32'hFFFFFFFF, fp32_pkg::RND_NEAREST_EVEN, 32'hBF800000, 1'b0},
    '{32'h00003039, fp32_pkg::RND_TO_ZERO,      32'h4640E400, 1'b0},
    '{32'h00800000, fp32_pkg::RND_NEAREST_EVEN, 32'h4B000000, 1'b0},
    '{32'h00FFFFFF, fp32_pkg::RND_TO_PLUS_INF,  32'h4B7FFFFF, 1'b0},
    '{32'h80000000, fp32_pkg::RND_TO_MINUS_INF, 32'hCF000000, 1'b0},
    // carry into the exponent gives 2^25
    '{32'h01FFFFFF, fp32_pkg::RND_NEAREST_EVEN, 32'h4C000000, 1'b1},
    '{32'h01FFFFFF, fp32_pkg::RND_TO_PLUS_INF,  32'h4C000000, 1'b1},
    '{32'h01FFFFFF, fp32_pkg::RND_TO_ZERO,      32'h4BFFFFFF, 1'b1},
    // ties resolve to even
    '{32'h01000003, fp32_pkg::RND_NEAREST_EVEN, 32'h4B800002, 1'b1},
    '{32'h01000001, fp32_pkg::RND_NEAREST_EVEN, 32'h4B800000, 1'b1},
    '{32'hFEFFFFFF, fp32_pkg::RND_TO_MINUS_INF, 32'hCB800001, 1'b1},
    // sticky only with guard clear
    '{32'h02000001, fp32_pkg::RND_NEAREST_EVEN, 32'h4C000000, 1'b1},
    '{32'h02000001, fp32_pkg::RND_TO_PLUS_INF,  32'h4C000001, 1'b1},
    '{32'h12345678, fp32_pkg::RND_NEAREST_EVEN, 32'h4D91A2B4, 1'b1},
    '{32'hEDCBA988, fp32_pkg::RND_TO_ZERO,      32'hCD91A2B3, 1'b1},
    '{32'h7FFFFFFF, fp32_pkg::RND_NEAREST_EVEN, 32'h4F000000, 1'b1},
    // directed modes against the sign truncate
    '{32'hFEFFFFFF, fp32_pkg::RND_TO_PLUS_INF,  32'hCB800000, 1'b1},
    '{32'h01000001, fp32_pkg::RND_TO_MINUS_INF, 32'h4B800000, 1'b1}
  };

  logic clk, rst, flush, adv, start, inexact, rdy;
  logic exp_push, exp_inexact;
  fp32_pkg::rnd_mode_e  rnd_mode;
  i2f_pkg::i2f_int_t    opa;
  fp32_pkg::fp32_word_t result, exp_result;
  int value_errs, proto_errs, pending;
  int unsigned seed_ret;
  int idx;

  i2f_unit i_dut (
    .clk(clk), .rst(rst), .flush_i(flush), .adv_i(adv), .start_i(start),
    .rnd_mode_i(rnd_mode), .opa_i(opa),
    .result_o(result), .inexact_o(inexact), .rdy_o(rdy)
  );

  i2f_checker u_checker (
    .clk(clk), .rst(rst), .adv_i(adv), .flush_i(flush), .rdy_i(rdy),
    .result_i(result), .inexact_i(inexact), .exp_push_i(exp_push),
    .exp_result_i(exp_result), .exp_inexact_i(exp_inexact),
    .value_errs_o(value_errs), .proto_errs_o(proto_errs), .pending_o(pending)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    repeat (LIMIT) @(posedge clk);
    $display("watchdog: run did not finish within %0d cycles", LIMIT);
    $display("SIMULATION FAILED");
    $finish;
  end

  task automatic present_row(input int row);
    start       = 1'b1;
    opa         = ROWS[row].op;
    rnd_mode    = ROWS[row].mode;
    exp_push    = 1'b1;
    exp_result  = ROWS[row].result;
    exp_inexact = ROWS[row].inexact;
  endtask

  task automatic drop_start();
    start    = 1'b0;
    exp_push = 1'b0;
  endtask

  // inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic drain();
    adv = 1'b1;
    drop_start();
    while (pending != 0) next_cycle();
  endtask

  initial begin
    seed_ret = $urandom(32'ha9b0348a);
    rst = 1'b1;
    flush = 1'b0;
    adv = 1'b1;
    rnd_mode = fp32_pkg::RND_NEAREST_EVEN;
    opa = '0;
    exp_result = '0;
    exp_inexact = 1'b0;
    drop_start();
    repeat (8) @(posedge clk);
    #1 rst = 1'b0;
    repeat (2) next_cycle();
    // back to back with adv held high
    for (idx = 0; idx < NROWS; idx++) begin
      present_row(idx);
      next_cycle();
    end
    drain();
    // random stalls with start only on adv-high edges
    idx = 0;
    while (idx < NROWS) begin
      drop_start();
      adv = ($urandom_range(3, 0) != 0);
      if (adv) begin
        present_row(idx);
        idx++;
      end
      next_cycle();
    end
    drain();
    // flush with two in flight and a third starting
    present_row(15);
    next_cycle();
    present_row(16);
    next_cycle();
    present_row(17);
    flush = 1'b1;
    next_cycle();
    flush = 1'b0;
    drop_start();
    repeat (4) next_cycle();
    present_row(7);
    next_cycle();
    drain();
    repeat (3) next_cycle();
    if (pending != 0) $display("%0d expected results never came", pending);
    $display("errors: value %0d, protocol %0d, left over %0d",
             value_errs, proto_errs, pending);
    if (value_errs == 0 && proto_errs == 0 && pending == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== i2f_unit.f ====
fp32_pkg.sv
i2f_pkg.sv
i2f_prenorm.sv
i2f_postnorm.sv
i2f_unit.sv
i2f_checker.sv
tb_i2f_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the int to float testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module tb_i2f_unit \
  -f i2f_unit.f \
  -o sim_i2f_unit

./obj_dir/sim_i2f_unit | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  echo "simulation reported failure"
  exit 1
fi

echo "simulation finished without failure"
exit 0
